/* cache_params.svh */
// cache geometry and bus width macros for the 8-way read cache
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////////////////////////
`define CACHE_WAYS  8   // ways per set
`define CACHE_SETS  16  // sets, one per index value
`define LINE_WORDS  8   // 16-bit words per line

//////////////////////////////////////////////////////////////////////
// bus and field widths
//////////////////////////////////////////////////////////////////////
`define ADDR_W      32  // cpu byte address
`define DATA_W      16  // cpu and memory data bus
`define WORD_SEL_W  3   // addr[3:1], word in line
`define INDEX_W     4   // addr[7:4], set select
`define TAG_W       24  // addr[31:8]
`define WAY_W       3   // way number
`define LRU_W       7   // tree nodes per set

`endif

/* cache_pkg.sv */
// shared bus, tag store and controller state types for the read cache
`include "cache_params.svh"

package cachePkg;

	//////////////////////////////////////////////////////////////////////
	// cpu side
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                req;     // held until ack seen
		logic                write;   // 1 write, 0 read
		logic [1:0]          byteEn;  // [1] upper byte, [0] lower byte
		logic [`ADDR_W-1:0]  addr;    // byte address
		logic [`DATA_W-1:0]  wrData;
	} cpuReq_t;

	typedef struct packed {
		logic                ack;     // high until req drops
		logic [`DATA_W-1:0]  rdData;  // valid with ack on reads
	} cpuRsp_t;

	//////////////////////////////////////////////////////////////////////
	// memory side
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                valid;   // held until burst or write completes
		logic                write;
		logic [1:0]          byteEn;
		logic [`ADDR_W-1:0]  addr;    // line aligned on reads
		logic [`DATA_W-1:0]  wrData;
	} memReq_t;

	typedef struct packed {
		logic                beat;    // one burst word on rdData
		logic                wrAck;   // single-cycle write done
		logic [`DATA_W-1:0]  rdData;
	} memRsp_t;

	// storage entries
	typedef struct packed {
		logic                valid;
		logic [`TAG_W-1:0]   tag;
	} tagEntry_t;

	typedef logic [`LRU_W-1:0]      lruBits_t;  // node 0 root, 1..2 mid, 3..6 leaf parents
	typedef logic [`CACHE_WAYS-1:0] wayVec_t;   // one bit per way

	typedef enum logic [2:0] {
		Invalidate, Idle, Lookup, HitWait, FillWait, Fill, FillDone, WriteThrough
	} cacheState_t;

endpackage

/* cache_ram.sv */
// generic storage array, async read and sync write, entry type set by parameter
`timescale 1ns/1ns
`include "cache_params.svh"

module cache_ram #(
	parameter type entryT = cachePkg::tagEntry_t,  // tag entry, data word or lru bits
	parameter int  depth  = `CACHE_SETS
) (
	input  logic                     Clock,
	input  logic                     we,       // write this cycle
	input  logic [$clog2(depth)-1:0] addr,     // shared by read and write
	input  entryT                    wrData,
	output entryT                    rdData
);

	// no reset here, the controller sweeps the arrays after power up
	entryT mem [depth];

	//////////////////////////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock) begin
		if (we) begin
			mem[addr] <= wrData;  // lands on the rising edge
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////////////

	// combinational read so tag compare and hit data
	// are ready in the same cycle the index is presented
	assign rdData = mem[addr];

	// a write shows on rdData only after the edge, which is what lets
	// the fill write a tag in one state and hit on it in a later one

endmodule

/* plru_tree.sv */
// tree pseudo-LRU: victim selection and next-state bits for an accessed way
`timescale 1ns/1ns
`include "cache_params.svh"

module plru_tree (
	input  cachePkg::lruBits_t   lruBits,    // current tree of the addressed set
	input  cachePkg::wayVec_t    hitVec,     // one-hot or zero
	output logic [`WAY_W-1:0]    victimWay,  // way the tree points at
	output cachePkg::lruBits_t   lruOnHit,   // tree after touching the hit way
	output cachePkg::lruBits_t   lruOnFill   // tree after touching the victim
);
	import cachePkg::*;

	logic rootDir;                 // 0 = ways 0..3, 1 = ways 4..7
	logic midDir;                  // half of the chosen quarter pair
	logic leafDir;                 // way inside the chosen pair
	logic [`WAY_W-1:0] hitWay;     // encoded hitVec

	// every node on the way's path is turned to point away from it
	function automatic lruBits_t touch(input lruBits_t bits, input logic [`WAY_W-1:0] way);
		lruBits_t upd;
		upd = bits;
		upd[0] = ~way[2];                // root
		upd[1 + way[2]] = ~way[1];       // node 1 or 2
		upd[3 + way[2:1]] = ~way[0];     // nodes 3..6
		return upd;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// victim walk, follow pointers from the root
	//////////////////////////////////////////////////////////////////////
	assign rootDir = lruBits[0];
	assign midDir = lruBits[1 + rootDir];
	assign leafDir = lruBits[3 + {rootDir, midDir}];
	assign victimWay = {rootDir, midDir, leafDir};

	// one-hot to binary, zero when nothing hit
	always_comb begin
		hitWay = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (hitVec[w]) begin
				hitWay = `WAY_W'(w);
			end
		end
	end

	assign lruOnHit = touch(lruBits, hitWay);
	assign lruOnFill = touch(lruBits, victimWay);  // controller picks which one it writes

	// the encoder above is only correct when the tag store never holds
	// a line twice in one set, skip cycles where sets are not swept yet
	always_comb begin
		if (!$isunknown(hitVec)) begin
			hitOneHot: assert final ($onehot0(hitVec))
				else $error("plru_tree: hitVec has more than one way set");
		end
	end

endmodule

/* cache_arrays.sv */
// per-way tag, valid and data stores plus the LRU store and the tag compare
`timescale 1ns/1ns
`include "cache_params.svh"

module cache_arrays (
	input  logic                     Clock,
	input  logic                     Reset_L,
	input  logic [`INDEX_W-1:0]      index,       // set select
	input  logic [`WORD_SEL_W-1:0]   wordSel,     // word in line
	input  logic [`TAG_W-1:0]        tag,         // cpu address tag
	input  cachePkg::wayVec_t        tagWe,       // per-way tag and valid write
	input  logic                     tagWrValid,  // valid bit to write
	input  cachePkg::wayVec_t        dataWe,      // per-way data write
	input  logic [`DATA_W-1:0]       wrWord,      // burst beat data
	output cachePkg::wayVec_t        hitVec,
	output logic [`DATA_W-1:0]       hitWord,
	input  logic                     lruWe,
	input  cachePkg::lruBits_t       lruWrBits,
	output cachePkg::lruBits_t       lruBits      // tree of the addressed set
);
	import cachePkg::*;

	localparam int DataDepth = `CACHE_SETS * `LINE_WORDS;  // set-major, word-minor

	tagEntry_t          tagWr;                     // shared write value, all ways
	tagEntry_t          tagRd [`CACHE_WAYS];
	logic [`DATA_W-1:0] dataRd [`CACHE_WAYS];

	// invalidating also zeroes the tag, a fill writes the cpu tag
	assign tagWr.valid = tagWrValid;
	assign tagWr.tag = tagWrValid ? tag : '0;

	//////////////////////////////////////////////////////////////////////
	// per-way stores
	//////////////////////////////////////////////////////////////////////
	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gWay
		cache_ram #(
			.entryT (tagEntry_t),
			.depth  (`CACHE_SETS)
		) i_tagRam (
			.Clock  (Clock),
			.we     (tagWe[w]),
			.addr   (index),
			.wrData (tagWr),
			.rdData (tagRd[w])
		);

		cache_ram #(
			.entryT (logic [`DATA_W-1:0]),
			.depth  (DataDepth)
		) i_dataRam (
			.Clock  (Clock),
			.we     (dataWe[w]),
			.addr   ({index, wordSel}),  // line base plus word
			.wrData (wrWord),
			.rdData (dataRd[w])
		);
	end

	// one tree per set
	cache_ram #(
		.entryT (lruBits_t),
		.depth  (`CACHE_SETS)
	) i_lruRam (
		.Clock  (Clock),
		.we     (lruWe),
		.addr   (index),
		.wrData (lruWrBits),
		.rdData (lruBits)
	);

	//////////////////////////////////////////////////////////////////////
	// tag compare and hit data select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		hitVec = '0;
		hitWord = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hitVec[w] = tagRd[w].valid && (tagRd[w].tag == tag);
			hitWord = hitWord | ({`DATA_W{hitVec[w]}} & dataRd[w]);  // and-or mux
		end
	end

	// fills only happen on a miss, so a tag can live in one way of a set
	singleHit: assert property (@(posedge Clock) disable iff (!Reset_L)
		!$isunknown(hitVec) |-> $onehot0(hitVec))
		else $error("cache_arrays: tag present in more than one way");

endmodule

/* cache_ctrl.sv */
// cache controller FSM: power-up invalidate, lookup, burst line fill and write-through
`timescale 1ns/1ns
`include "cache_params.svh"

module cache_ctrl (
	input  logic                     Clock,
	input  logic                     Reset_L,
	input  cachePkg::cpuReq_t        cpuReq,
	output cachePkg::cpuRsp_t        cpuRsp,
	output cachePkg::memReq_t        memReq,
	input  cachePkg::memRsp_t        memRsp,
	output logic [`INDEX_W-1:0]      index,       // to arrays
	output logic [`WORD_SEL_W-1:0]   wordSel,
	output cachePkg::wayVec_t        tagWe,
	output logic                     tagWrValid,
	output cachePkg::wayVec_t        dataWe,
	output logic                     lruWe,
	output cachePkg::lruBits_t       lruWrBits,
	input  cachePkg::wayVec_t        hitVec,      // from arrays
	input  logic [`DATA_W-1:0]       hitWord,
	input  logic [`WAY_W-1:0]        victimWay,   // from plru tree
	input  cachePkg::lruBits_t       lruOnHit,
	input  cachePkg::lruBits_t       lruOnFill
);
	import cachePkg::*;

	localparam int IndexLsb = `WORD_SEL_W + 1;  // addr[0] is the byte lane

	cacheState_t                  state;
	cacheState_t                  nextState;
	logic [`INDEX_W-1:0]          setCnt;     // invalidate sweep
	logic [$clog2(`LINE_WORDS):0] beatCnt;    // 0..LINE_WORDS
	logic [`WAY_W-1:0]            victimReg;  // way being filled
	wayVec_t                      victimVec;
	logic                         isHit;
	logic                         filling;
	logic                         beatIn;

	assign isHit = |hitVec;
	assign filling = (state == FillWait) || (state == Fill);
	assign beatIn = filling && memRsp.beat;  // a beat only counts while a burst is open

	//////////////////////////////////////////////////////////////////////
	// state and counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= Invalidate;  // sweep the arrays first
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			setCnt <= '0;
		end else if (state == Invalidate) begin
			setCnt <= setCnt + 1'b1;  // one set per cycle
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			beatCnt <= '0;
		end else if (state == Lookup) begin
			beatCnt <= '0;             // fresh count for each burst
		end else if (beatIn) begin
			beatCnt <= beatCnt + 1'b1;
		end
	end

	// victim held from lookup through the whole fill
	always_ff @(posedge Clock) begin
		if (state == Lookup) begin
			victimReg <= victimWay;
		end
	end

	always_comb begin
		victimVec = '0;
		victimVec[victimReg] = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;

		// array addressing follows the cpu unless sweeping or filling
		index = cpuReq.addr[IndexLsb +: `INDEX_W];
		wordSel = filling ? beatCnt[`WORD_SEL_W-1:0] : cpuReq.addr[1 +: `WORD_SEL_W];

		cpuRsp.ack = 1'b0;
		cpuRsp.rdData = hitWord;           // only meaningful with ack

		memReq.valid = 1'b0;
		memReq.write = 1'b0;
		memReq.byteEn = 2'b11;             // reads fetch whole words
		memReq.addr = cpuReq.addr;
		memReq.addr[IndexLsb-1:0] = '0;    // line aligned burst
		memReq.wrData = cpuReq.wrData;

		tagWe = '0;
		tagWrValid = 1'b0;
		dataWe = beatIn ? victimVec : '0;  // each beat lands in the victim way
		lruWe = 1'b0;
		lruWrBits = lruOnHit;

		case (state)
			Invalidate: begin
				index = setCnt;
				tagWe = '1;                    // all ways at once
				lruWe = 1'b1;
				lruWrBits = '0;
				if (setCnt == (`CACHE_SETS - 1)) begin
					nextState = Idle;
				end
			end
			Idle: begin
				if (cpuReq.req && cpuReq.write) begin
					tagWe = hitVec;            // a write hit drops the line with valid 0
					nextState = WriteThrough;
				end else if (cpuReq.req) begin
					nextState = Lookup;
				end
			end
			Lookup: begin
				lruWe = 1'b1;
				if (isHit) begin
					cpuRsp.ack = 1'b1;         // one cycle after idle saw req
					nextState = HitWait;
				end else begin
					lruWrBits = lruOnFill;     // victim becomes most recent
					nextState = FillWait;
				end
			end
			FillWait: begin
				memReq.valid = 1'b1;
				tagWe = victimVec;             // claim the way before data arrives
				tagWrValid = 1'b1;
				nextState = Fill;
			end
			Fill: begin
				memReq.valid = 1'b1;
				if (beatIn && (beatCnt == (`LINE_WORDS - 1))) begin
					nextState = FillDone;      // valid drops after the eighth beat
				end
			end
			WriteThrough: begin
				memReq.valid = 1'b1;
				memReq.write = 1'b1;
				memReq.byteEn = cpuReq.byteEn;
				memReq.addr = cpuReq.addr;     // full address for writes
				if (memRsp.wrAck) begin
					nextState = HitWait;
				end
			end
			HitWait, FillDone: begin
				cpuRsp.ack = 1'b1;             // hold until cpu ends the cycle
				if (!cpuReq.req) begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = Idle;
			end
		endcase
	end

	// the cpu is answered only once the memory cycle has closed
	ackAfterMem: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(cpuRsp.ack) && $past(memReq.valid) |-> !memReq.valid &&
			($past(memReq.write) ? $past(memRsp.wrAck) : (beatCnt == `LINE_WORDS)))
		else $error("cache_ctrl: ack raised before the memory cycle completed");

	beatBound: assert property (@(posedge Clock) disable iff (!Reset_L)
		beatCnt <= `LINE_WORDS)
		else $error("cache_ctrl: more than a line of beats counted");

endmodule

/* cache_top.sv */
// read cache top level: controller, storage arrays and pseudo-LRU logic
`timescale 1ns/1ns
`include "cache_params.svh"

module cache_top (
	input  logic               Clock,
	input  logic               Reset_L,
	input  cachePkg::cpuReq_t  cpuReq,
	output cachePkg::cpuRsp_t  cpuRsp,
	output cachePkg::memReq_t  memReq,
	input  cachePkg::memRsp_t  memRsp
);
	import cachePkg::*;

	// controller to arrays
	logic [`INDEX_W-1:0]    index;
	logic [`WORD_SEL_W-1:0] wordSel;
	wayVec_t                tagWe;
	logic                   tagWrValid;
	wayVec_t                dataWe;
	logic                   lruWe;
	lruBits_t               lruWrBits;

	// arrays to controller and tree
	wayVec_t                hitVec;
	logic [`DATA_W-1:0]     hitWord;
	lruBits_t               lruBits;

	// tree to controller
	logic [`WAY_W-1:0]      victimWay;
	lruBits_t               lruOnHit;
	lruBits_t               lruOnFill;

	cache_ctrl i_ctrl (
		.Clock, .Reset_L, .cpuReq, .cpuRsp, .memReq, .memRsp,
		.index, .wordSel, .tagWe, .tagWrValid, .dataWe, .lruWe, .lruWrBits,
		.hitVec, .hitWord, .victimWay, .lruOnHit, .lruOnFill
	);

	cache_arrays i_arrays (
		.Clock, .Reset_L, .index, .wordSel,
		.tag    (cpuReq.addr[`ADDR_W-1 -: `TAG_W]),  // addr[31:8]
		.tagWe, .tagWrValid, .dataWe,
		.wrWord (memRsp.rdData),                     // only written on fill beats
		.hitVec, .hitWord, .lruWe, .lruWrBits, .lruBits
	);

	plru_tree i_plru (
		.lruBits, .hitVec, .victimWay, .lruOnHit, .lruOnFill
	);

endmodule

/* tb_mem_model.sv */
// memory responder for the cache testbench with burst reads, acked writes and a sparse store
`timescale 1ns/1ns
`include "cache_params.svh"

module tb_mem_model #(
	parameter logic [31:0] latencySeed = 32'h1
) (
	input  logic               Clock,
	input  cachePkg::memReq_t  memReq,
	output cachePkg::memRsp_t  memRsp,
	output int                 burstCount,  // line bursts served
	output int                 writeCount,  // writes acked
	output cachePkg::memReq_t  lastWrite    // request as seen at wrAck
);
	import cachePkg::*;

	logic [`DATA_W-1:0] store [logic [`ADDR_W-1:0]];  // written words only
	integer seed;

	// power-up contents, odd multiplier mixes every address bit
	function automatic logic [`DATA_W-1:0] fillPattern(input logic [`ADDR_W-1:0] addr);
		logic [31:0] h;
		h = {addr[31:1], 1'b0} * 32'h9e3779b1;
		return h[31:16] ^ h[15:0];
	endfunction

	function automatic logic [`DATA_W-1:0] readWord(input logic [`ADDR_W-1:0] addr);
		logic [`ADDR_W-1:0] key;
		key = {addr[31:1], 1'b0};
		return store.exists(key) ? store[key] : fillPattern(key);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// request loop, one memory cycle at a time
	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [`ADDR_W-1:0] base;
		logic [`DATA_W-1:0] word;
		seed = latencySeed;
		memRsp <= '0;
		burstCount = 0;
		writeCount = 0;
		lastWrite = '0;
		forever begin
			@(posedge Clock);
			if (memReq.valid && memReq.write) begin
				repeat ($random(seed) & 3) @(posedge Clock);  // 0..3 cycles write latency
				word = readWord(memReq.addr);
				if (memReq.byteEn[1]) word[15:8] = memReq.wrData[15:8];  // upper lane
				if (memReq.byteEn[0]) word[7:0] = memReq.wrData[7:0];
				store[{memReq.addr[31:1], 1'b0}] = word;
				lastWrite = memReq;
				writeCount++;
				memRsp.wrAck <= 1'b1;
				@(posedge Clock);
				memRsp.wrAck <= 1'b0;  // valid is gone on the next edge
			end else if (memReq.valid) begin
				base = memReq.addr;    // line aligned
				burstCount++;
				repeat ($random(seed) & 3) @(posedge Clock);  // delay before first beat
				for (int i = 0; i < `LINE_WORDS; i++) begin
					memRsp.beat <= 1'b1;
					memRsp.rdData <= readWord(base + 2 * i);
					@(posedge Clock);
					if ((i < `LINE_WORDS - 1) && (($random(seed) & 3) == 0)) begin
						memRsp.beat <= 1'b0;  // idle gap between beats
						@(posedge Clock);
					end
				end
				memRsp.beat <= 1'b0;
			end
		end
	end

endmodule

/* tb_cache.sv */
// testbench top for the read cache with directed and random accesses checked against a model
`timescale 1ns/1ns
`include "cache_params.svh"

module tb_cache;
	import cachePkg::*;

	localparam int AckLimit = 200;  // cycles for any one handshake step
	// ways taken by eight misses into an empty set with fill 0 in the low bits
	localparam logic [23:0] FillOrder = {3'd7, 3'd3, 3'd5, 3'd1, 3'd6, 3'd2, 3'd4, 3'd0};

	logic    Clock;
	logic    Reset_L;
	cpuReq_t cpuReq;
	cpuRsp_t cpuRsp;
	memReq_t memReq;
	memRsp_t memRsp;
	int      burstCount;
	int      writeCount;
	memReq_t lastWrite;

	integer  seed;
	string   testName;
	int      errCount;
	int      checkCount;
	int      errStart;    // counts when the current test began
	int      checkStart;
	bit      timedOut;

	// reference model of tags, valid bits, trees and memory
	logic [`TAG_W-1:0]  mTag [`CACHE_SETS][`CACHE_WAYS];
	logic               mValid [`CACHE_SETS][`CACHE_WAYS];
	logic [`LRU_W-1:0]  mLru [`CACHE_SETS];
	logic [`DATA_W-1:0] shadow [logic [`ADDR_W-1:0]];  // words written so far

	cache_top i_dut (.Clock, .Reset_L, .cpuReq, .cpuRsp, .memReq, .memRsp);

	tb_mem_model #(.latencySeed(32'h884b59e0)) i_mem (
		.Clock, .memReq, .memRsp, .burstCount, .writeCount, .lastWrite
	);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;  // 4 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// model helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [`DATA_W-1:0] memWord(input logic [`ADDR_W-1:0] addr);
		logic [`ADDR_W-1:0] key;
		logic [31:0] h;
		key = {addr[31:1], 1'b0};
		h = key * 32'h9e3779b1;  // same power-up contents as the memory
		return shadow.exists(key) ? shadow[key] : (h[31:16] ^ h[15:0]);
	endfunction

	// heap order with node n over 2n+1 and 2n+2 and bit 0 pointing low
	function automatic logic [`WAY_W-1:0] victimOf(input logic [`LRU_W-1:0] bits);
		int node;
		logic [`WAY_W-1:0] way;
		node = 0;
		for (int lvl = `WAY_W - 1; lvl >= 0; lvl--) begin
			way[lvl] = bits[node];
			node = 2 * node + 1 + bits[node];
		end
		return way;
	endfunction

	function automatic logic [`LRU_W-1:0] touchWay(input logic [`LRU_W-1:0] bits,
			input logic [`WAY_W-1:0] way);
		int node;
		node = 0;
		for (int lvl = `WAY_W - 1; lvl >= 0; lvl--) begin
			bits[node] = ~way[lvl];  // point away from the accessed way
			node = 2 * node + 1 + way[lvl];
		end
		return bits;
	endfunction

	task automatic startTest(input string name);
		testName = name;
		errStart = errCount;
		checkStart = checkCount;
	endtask

	task automatic endTest();
		$display("test %-14s %0d checks, %0d errors", testName,
			checkCount - checkStart, errCount - errStart);
	endtask

	//////////////////////////////////////////////////////////////////////
	// one cpu access predicted by the model and then checked
	//////////////////////////////////////////////////////////////////////
	task automatic access(input logic write, input logic [1:0] be,
			input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		int set;
		int hitWay;
		int bursts;
		int expBursts;
		int writes;
		int expWrites;
		int cycles;
		logic [`DATA_W-1:0] expData;
		logic [`DATA_W-1:0] gotData;
		logic [`DATA_W-1:0] word;
		logic [`WAY_W-1:0] victim;
		memReq_t expWrite;
		if (!timedOut) begin
			set = addr[7:4];
			hitWay = -1;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (mValid[set][w] && (mTag[set][w] == addr[31:8])) hitWay = w;
			end
			expBursts = (!write && (hitWay < 0)) ? 1 : 0;  // only read misses burst
			expWrites = write ? 1 : 0;                     // every write goes out once
			bursts = burstCount;
			writes = writeCount;
			@(posedge Clock);
			cpuReq <= {1'b1, write, be, addr, data};  // req, write, byteEn, addr, wrData
			cycles = 0;
			while (!cpuRsp.ack && (cycles < AckLimit)) begin
				@(negedge Clock);
				cycles++;
			end
			if (!cpuRsp.ack) begin
				timedOut = 1'b1;
				$display("timeout in %s: no ack for the access to %h", testName, addr);
			end
			gotData = cpuRsp.rdData;
			@(posedge Clock);
			cpuReq.req <= 1'b0;  // end the cycle on the edge after ack
			cycles = 0;
			while (cpuRsp.ack && (cycles < AckLimit)) begin
				@(negedge Clock);
				cycles++;
			end
			if (cpuRsp.ack) begin
				timedOut = 1'b1;
				$display("timeout in %s: ack stayed high after req dropped", testName);
			end
		end
		if (!timedOut) begin
			checkCount++;
			if ((burstCount - bursts) != expBursts) begin
				errCount++;
				$display("[ERROR] %s: bursts for %h expected %0d actual %0d", testName, addr,
					expBursts, burstCount - bursts);
			end
			checkCount++;
			if ((writeCount - writes) != expWrites) begin
				errCount++;
				$display("[ERROR] %s: writes for %h expected %0d actual %0d", testName, addr,
					expWrites, writeCount - writes);
			end
			if (write) begin
				expWrite = {1'b1, 1'b1, be, addr, data};
				checkCount++;
				if (lastWrite !== expWrite) begin
					errCount++;
					$display("[ERROR] %s: memory write expected %h actual %h", testName,
						expWrite, lastWrite);
				end
				if (hitWay >= 0) mValid[set][hitWay] = 1'b0;  // write hit drops the line
				word = memWord(addr);
				if (be[1]) word[15:8] = data[15:8];
				if (be[0]) word[7:0] = data[7:0];
				shadow[{addr[31:1], 1'b0}] = word;
			end else begin
				expData = memWord(addr);
				checkCount++;
				if (gotData !== expData) begin
					errCount++;
					$display("[ERROR] %s: read of %h expected %h actual %h", testName, addr,
						expData, gotData);
				end
				victim = (hitWay >= 0) ? hitWay[`WAY_W-1:0] : victimOf(mLru[set]);
				mTag[set][victim] = addr[31:8];
				mValid[set][victim] = 1'b1;
				mLru[set] = touchWay(mLru[set], victim);
			end
		end
	endtask

	// fill n of an empty set must land in the way the tree order gives
	task automatic checkFillWay(input int n);
		logic [`WAY_W-1:0] expWay;
		expWay = FillOrder[n * 3 +: 3];
		if (!timedOut) begin
			checkCount++;
			if (i_dut.i_ctrl.victimReg !== expWay) begin
				errCount++;
				$display("[ERROR] %s: fill %0d way expected %0d actual %0d", testName, n,
					expWay, i_dut.i_ctrl.victimReg);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] r;
		logic [3:0] tagLow;
		seed = 32'h884b59e0;
		Reset_L = 1'b0;
		cpuReq = '0;
		errCount = 0;
		checkCount = 0;
		timedOut = 1'b0;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			mLru[s] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				mValid[s][w] = 1'b0;
				mTag[s][w] = '0;
			end
		end
		repeat (2) @(posedge Clock);
		Reset_L <= 1'b1;  // first request waits out the sweep

		startTest("invalidate");
		access(1'b0, 2'b11, 32'h0001_2340, '0);
		access(1'b0, 2'b11, 32'h00ab_cd52, '0);
		endTest();

		startTest("read hit");
		for (int i = 0; i < `LINE_WORDS; i++) access(1'b0, 2'b11, 32'h0001_2340 + 2 * i, '0);
		endTest();

		startTest("fill order");
		for (int i = 0; i < 8; i++) begin
			access(1'b0, 2'b11, 32'h0001_0090 + (i << 8), '0);  // tags from 0x100 up in set 9
			checkFillWay(i);
		end
		access(1'b0, 2'b11, 32'h0001_0890, '0);  // ninth tag takes way 0
		access(1'b0, 2'b11, 32'h0001_0196, '0);  // second tag still there
		access(1'b0, 2'b11, 32'h0001_009a, '0);  // first tag comes back by burst
		endTest();

		startTest("write-through");
		access(1'b0, 2'b11, 32'h0001_2346, '0);
		access(1'b1, 2'b01, 32'h0001_2346, 16'hc35a);  // hit drops the line
		access(1'b0, 2'b11, 32'h0001_2346, '0);
		access(1'b1, 2'b11, 32'h0077_7740, 16'h1234);  // miss in the same set
		access(1'b0, 2'b11, 32'h0001_2340, '0);
		access(1'b0, 2'b11, 32'h0077_7740, '0);
		access(1'b1, 2'b10, 32'h0077_7744, 16'hbeef);
		endTest();

		startTest("random mix");
		for (int n = 0; n < 300; n++) begin
			r = $random(seed);
			tagLow = r[3:0] % 4'd12;  // twelve tags over eight ways
			access(r[9:8] == 2'b00, (r[11:10] == 2'b00) ? 2'b11 : r[11:10],
				{20'h00020, tagLow, 3'b001, r[4], r[7:5], 1'b0}, r[31:16]);
		end
		endTest();

		$display("summary: %0d checks, %0d errors", checkCount, errCount);
		if (timedOut || (errCount != 0)) begin
			$display("TEST RESULT: FAIL");
		end else begin
			$display("TEST RESULT: PASS");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
cache_pkg.sv
cache_ram.sv
plru_tree.sv
cache_arrays.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv
